// File: lfo_pkg.sv
package lfo_pkg;

//////////////////////////////
// sizes
//////////////////////////////

localparam int LFO_PRESCALE = 16;                   // clocks per prescaler step
localparam int PRESCALE_W   = $clog2(LFO_PRESCALE);
localparam int HI_CNTR_W    = 15;                   // rate high counter
localparam int PHASE_W      = 8;
localparam int DEPTH_W      = 7;                    // amd / pmd width
localparam int OUT_W        = 8;                    // lfa / lfp width
localparam int ADDR_W       = 3;

// register map
localparam logic [ADDR_W-1:0] ADDR_LFRQ  = 3'd0;
localparam logic [ADDR_W-1:0] ADDR_DEPTH = 3'd1;   // bit 7 picks pmd
localparam logic [ADDR_W-1:0] ADDR_CTRL  = 3'd2;
localparam logic [ADDR_W-1:0] ADDR_PHASE = 3'd3;   // read only

// waveform codes, 3 runs as saw
localparam logic [1:0] WAVE_SAW    = 2'd0;
localparam logic [1:0] WAVE_SQUARE = 2'd1;
localparam logic [1:0] WAVE_TRI    = 2'd2;

localparam logic [DEPTH_W-1:0] BASE_MAX       = '1;     // full scale base value
localparam logic [OUT_W-1:0]   LFP_ZERO_DEPTH = 8'h80;  // lfp when pmd is zero

//////////////////////////////
// types
//////////////////////////////

typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [7:0]        pwdata;
} apb_req_t;

typedef struct packed {
    logic       pready;
    logic       pslverr;
    logic [7:0] prdata;
} apb_rsp_t;

typedef struct packed {
    logic [3:0] exponent;   // lfrq[7:4]
    logic [3:0] mantissa;   // lfrq[3:0]
} lfrq_view_t;

typedef struct packed {
    logic               is_pm;  // 1 writes pmd, 0 writes amd
    logic [DEPTH_W-1:0] depth;
} depth_view_t;

// one written byte, two decodes
typedef union packed {
    lfrq_view_t  lfrq_view;
    depth_view_t depth_view;
} reg_data_u;

typedef struct packed {
    logic [7:0]         lfrq;
    logic [DEPTH_W-1:0] amd;
    logic [DEPTH_W-1:0] pmd;
    logic [1:0]         wave;
    logic               phase_hold;
    logic               lfrq_wr;    // one clock after an lfrq write
} lfo_cfg_t;

typedef struct packed {
    logic [DEPTH_W-1:0] am_base;
    logic [DEPTH_W-1:0] pm_mag;
    logic               pm_sign;    // 1 = negative
} base_val_t;

// preload for the high counter, top e bits of 7FFF above e = 1
function automatic logic [HI_CNTR_W-1:0] rate_lut(input logic [3:0] e);
    logic [HI_CNTR_W-1:0] ones;
    ones = '1;
    case (e)
        4'd0:    rate_lut = 15'h1000;
        4'd1:    rate_lut = 15'h4000;
        default: rate_lut = ~(ones >> e);
    endcase
endfunction

endpackage

// File: lfo_regs.sv
`timescale 1ns/100ps

module lfo_regs (
    input  logic                        i_EMUCLK,
    input  logic                        mrst_n,
    input  lfo_pkg::apb_req_t           i_apb,
    input  logic [lfo_pkg::PHASE_W-1:0] i_phase,
    output lfo_pkg::apb_rsp_t           o_apb,
    output lfo_pkg::lfo_cfg_t           o_cfg
);
    import lfo_pkg::*;

    logic      access;      // apb access phase
    logic      addr_err;    // 4..7 not mapped
    logic      ro_wr;       // write to phase readback
    logic      wr_en;
    reg_data_u wdata;
    lfo_cfg_t  cfg_q;
    logic [7:0] rdata;

    //////////////////////////////
    // apb decode
    //////////////////////////////

    assign access   = i_apb.psel & i_apb.penable;
    assign addr_err = (i_apb.paddr > ADDR_PHASE);
    assign ro_wr    = i_apb.pwrite & (i_apb.paddr == ADDR_PHASE);
    assign wr_en    = access & i_apb.pwrite & ~addr_err & ~ro_wr;
    assign wdata    = i_apb.pwdata;

    // register file, written on the access edge
    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            cfg_q <= '0;
        end else begin
            cfg_q.lfrq_wr <= 1'b0; // strobe
            if (wr_en) begin
                case (i_apb.paddr)
                    ADDR_LFRQ: begin
                        cfg_q.lfrq    <= wdata.lfrq_view;
                        cfg_q.lfrq_wr <= 1'b1;  // reload high counter next clock
                    end
                    ADDR_DEPTH: begin
                        if (wdata.depth_view.is_pm) begin
                            cfg_q.pmd <= wdata.depth_view.depth;
                        end else begin
                            cfg_q.amd <= wdata.depth_view.depth;
                        end
                    end
                    ADDR_CTRL: begin
                        cfg_q.wave       <= i_apb.pwdata[1:0];
                        cfg_q.phase_hold <= i_apb.pwdata[2];
                    end
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////
    // readback
    //////////////////////////////

    always_comb begin
        rdata = '0;
        case (i_apb.paddr)
            ADDR_LFRQ:  rdata = cfg_q.lfrq;
            ADDR_DEPTH: rdata = {1'b0, cfg_q.amd};                     // pmd not readable
            ADDR_CTRL:  rdata = {5'd0, cfg_q.phase_hold, cfg_q.wave};
            ADDR_PHASE: rdata = i_phase;                               // live phase copy
            default:    rdata = '0;
        endcase
    end

    // never stalls
    assign o_apb = '{pready: 1'b1, pslverr: access & (addr_err | ro_wr), prdata: rdata};
    assign o_cfg = cfg_q;

    // master must open every transfer with a setup phase
    ap_penable_psel: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        i_apb.penable |-> i_apb.psel);

endmodule

// File: lfo_rate_gen.sv
`timescale 1ns/100ps

module lfo_rate_gen (
    input  logic              i_EMUCLK,
    input  logic              mrst_n,
    input  lfo_pkg::lfo_cfg_t i_cfg,
    output logic              o_tick
);
    import lfo_pkg::*;

    reg_data_u               lfrq_w;    // exponent / mantissa view of lfrq
    logic [PRESCALE_W-1:0]   pre_cnt;
    logic                    step;      // one clock in 16
    logic [HI_CNTR_W-1:0]    hi_cnt;
    logic                    hi_wrap;
    logic                    hi_ld;
    logic [3:0]              lo_cnt;
    logic                    lo_pend;
    logic                    lo_sel;
    logic                    lo_tick;

    assign lfrq_w = i_cfg.lfrq;

    //////////////////////////////
    // prescaler
    //////////////////////////////

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1; // free running, wraps at 15
        end
    end

    assign step = (pre_cnt == PRESCALE_W'(LFO_PRESCALE - 1));

    //////////////////////////////
    // high counter
    //////////////////////////////

    assign hi_wrap = step & (&hi_cnt);  // 7FFF on a step

    // reload one clock after a wrap or an lfrq write
    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            hi_ld <= 1'b0;
        end else begin
            hi_ld <= hi_wrap | i_cfg.lfrq_wr;
        end
    end

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            hi_cnt <= '0;
        end else if (hi_ld) begin
            hi_cnt <= rate_lut(lfrq_w.lfrq_view.exponent); // table preload
        end else if (step) begin
            hi_cnt <= hi_cnt + 1'b1;    // 7FFF rolls to 0 until the reload
        end
    end

    //////////////////////////////
    // low counter, mantissa ticks
    //////////////////////////////

    // count ending picks the mantissa bit, 1111 never fires
    always_comb begin
        casez (lo_cnt)
            4'b???0: lo_sel = lfrq_w.lfrq_view.mantissa[3];
            4'b??01: lo_sel = lfrq_w.lfrq_view.mantissa[2];
            4'b?011: lo_sel = lfrq_w.lfrq_view.mantissa[1];
            4'b0111: lo_sel = lfrq_w.lfrq_view.mantissa[0];
            default: lo_sel = 1'b0;
        endcase
    end

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            lo_cnt  <= '0;
            lo_pend <= 1'b0;
            lo_tick <= 1'b0;
        end else begin
            if (hi_wrap) begin
                lo_cnt <= lo_cnt + 1'b1;    // advances on every high wrap
            end
            lo_pend <= hi_wrap;
            lo_tick <= lo_pend & lo_sel;    // extra tick, clear of the wrap tick
        end
    end

    assign o_tick = hi_wrap | lo_tick;

    // wrap tick and mantissa tick stay apart
    ap_tick_gap: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        (o_tick && (lfrq_w.lfrq_view.exponent != 4'hF)) |=> !o_tick);

endmodule

// File: lfo_phase_gen.sv
`timescale 1ns/100ps

module lfo_phase_gen (
    input  logic                        i_EMUCLK,
    input  logic                        mrst_n,
    input  lfo_pkg::lfo_cfg_t           i_cfg,
    input  logic                        i_tick,
    output logic [lfo_pkg::PHASE_W-1:0] o_phase,
    output lfo_pkg::base_val_t          o_base
);
    import lfo_pkg::*;

    logic [PHASE_W-1:0] phase;
    logic               p_msb;      // second half of the cycle
    base_val_t          saw_v;
    base_val_t          sq_v;
    base_val_t          tri_v;
    base_val_t          base;

    //////////////////////////////
    // phase counter
    //////////////////////////////

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            phase <= '0;
        end else if (i_cfg.phase_hold) begin
            phase <= '0;                // held at zero
        end else if (i_tick) begin
            phase <= phase + 1'b1;      // wraps at 256
        end
    end

    assign p_msb = phase[PHASE_W-1];

    //////////////////////////////
    // base values per waveform
    //////////////////////////////

    always_comb begin
        // saw, am falls over the whole cycle
        saw_v.am_base = BASE_MAX - phase[7:1];
        saw_v.pm_mag  = phase[6:0];
        saw_v.pm_sign = p_msb;

        // square
        sq_v.am_base  = p_msb ? '0 : BASE_MAX;
        sq_v.pm_mag   = BASE_MAX;   // full swing, sign flips
        sq_v.pm_sign  = p_msb;

        // triangle, am down then up
        tri_v.am_base = p_msb ? phase[6:0] : (BASE_MAX - phase[6:0]);
        // pm rises over each quarter and falls back
        tri_v.pm_mag  = phase[6] ? {~phase[5:0], 1'b0} : {phase[5:0], 1'b0};
        tri_v.pm_sign = p_msb;
    end

    always_comb begin
        case (i_cfg.wave)
            WAVE_SAW:    base = saw_v;
            WAVE_SQUARE: base = sq_v;
            WAVE_TRI:    base = tri_v;
            default:     base = saw_v;  // code 3 falls back to saw
        endcase
    end

    assign o_phase = phase;
    assign o_base  = base;

endmodule

// File: lfo_depth_mul.sv
`timescale 1ns/100ps

module lfo_depth_mul (
    input  logic                      i_EMUCLK,
    input  logic                      mrst_n,
    input  lfo_pkg::lfo_cfg_t         i_cfg,
    input  lfo_pkg::base_val_t        i_base,
    output logic [lfo_pkg::OUT_W-1:0] o_lfa,
    output logic [lfo_pkg::OUT_W-1:0] o_lfp
);
    import lfo_pkg::*;

    logic [3:0]             bit_cnt;
    logic                   pm_half;    // 0..7 am, 8..15 pm
    logic                   half_start;
    logic                   half_end;
    logic [DEPTH_W-1:0]     base_q;
    logic [DEPTH_W-1:0]     depth_sr;   // msb is the live depth bit
    logic                   sign_q;
    logic                   zero_q;
    logic [2*DEPTH_W-1:0]   acc;
    logic [2*DEPTH_W-1:0]   acc_nxt;
    logic [2*DEPTH_W-1:0]   part;       // partial product this step
    logic [OUT_W-1:0]       lfa_q;
    logic [OUT_W-1:0]       lfp_q;

    //////////////////////////////
    // bit counter
    //////////////////////////////

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;  // free running 0..15
        end
    end

    assign pm_half    = bit_cnt[3];
    assign half_start = (bit_cnt[2:0] == 3'd0);
    assign half_end   = (bit_cnt[2:0] == 3'd7);

    //////////////////////////////
    // serial shift-add
    //////////////////////////////

    // msb first, double and add
    assign part    = depth_sr[DEPTH_W-1] ? {{DEPTH_W{1'b0}}, base_q} : '0;
    assign acc_nxt = {acc[2*DEPTH_W-2:0], 1'b0} + part;

    always_ff @(posedge i_EMUCLK) begin
        if (half_start) begin
            // sample base and depth for this half
            base_q   <= pm_half ? i_base.pm_mag : i_base.am_base;
            depth_sr <= pm_half ? i_cfg.pmd : i_cfg.amd;
            sign_q   <= i_base.pm_sign;
            zero_q   <= (i_cfg.pmd == '0);
            acc      <= '0;
        end else begin
            acc      <= acc_nxt;            // steps 1..7
            depth_sr <= depth_sr << 1;
        end
    end

    //////////////////////////////
    // output registers
    //////////////////////////////

    // step 7 result goes straight in at the last count
    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            lfa_q <= '0;
            lfp_q <= '0;
        end else if (half_end) begin
            if (!pm_half) begin
                lfa_q <= acc_nxt[2*DEPTH_W-1 -: OUT_W];   // product >> 6
            end else if (zero_q) begin
                lfp_q <= LFP_ZERO_DEPTH;
            end else begin
                lfp_q <= {sign_q, acc_nxt[2*DEPTH_W-1 -: DEPTH_W]}; // sign, product >> 7
            end
        end
    end

    assign o_lfa = lfa_q;
    assign o_lfp = lfp_q;

    // each output changes only right after its own half ends
    ap_lfa_slot: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        !$stable(o_lfa) |-> ($past(bit_cnt) == 4'd7));
    ap_lfp_slot: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        !$stable(o_lfp) |-> ($past(bit_cnt) == 4'd15));

endmodule

// File: lfo_top.sv
`timescale 1ns/100ps

module lfo_top (
    input  logic                      i_EMUCLK,
    input  logic                      mrst_n,
    input  lfo_pkg::apb_req_t         i_apb,
    output lfo_pkg::apb_rsp_t         o_apb,
    output logic [lfo_pkg::OUT_W-1:0] o_lfa,
    output logic [lfo_pkg::OUT_W-1:0] o_lfp
);
    import lfo_pkg::*;

    lfo_cfg_t           cfg;    // register state to all blocks
    logic               tick;
    logic [PHASE_W-1:0] phase;
    base_val_t          base;

    //////////////////////////////
    // blocks
    //////////////////////////////

    lfo_regs u_regs (
        .i_EMUCLK (i_EMUCLK),
        .mrst_n   (mrst_n),
        .i_apb    (i_apb),
        .i_phase  (phase),
        .o_apb    (o_apb),
        .o_cfg    (cfg)
    );

    lfo_rate_gen u_rate (
        .i_EMUCLK (i_EMUCLK),
        .mrst_n   (mrst_n),
        .i_cfg    (cfg),
        .o_tick   (tick)
    );

    lfo_phase_gen u_phase (
        .i_EMUCLK (i_EMUCLK),
        .mrst_n   (mrst_n),
        .i_cfg    (cfg),
        .i_tick   (tick),
        .o_phase  (phase),
        .o_base   (base)
    );

    lfo_depth_mul u_mul (
        .i_EMUCLK (i_EMUCLK),
        .mrst_n   (mrst_n),
        .i_cfg    (cfg),
        .i_base   (base),
        .o_lfa    (o_lfa),
        .o_lfp    (o_lfp)
    );

endmodule

// File: tb_lfo.sv
`timescale 1ns/100ps

module tb_lfo;
    import lfo_pkg::*;

    localparam int MAX_CYCLES = 40000;  // about twice the sum of all tests

    logic       i_EMUCLK;
    logic       mrst_n;
    apb_req_t   i_apb;
    apb_rsp_t   o_apb;
    logic [7:0] o_lfa;
    logic [7:0] o_lfp;

    logic [31:0] rng;
    int          err_count;
    int          check_count;
    int          test_count;
    int          err_mark;
    int          cycles;
    logic [7:0]  exp_lfa;
    logic [7:0]  exp_lfp;
    logic [7:0]  chk_phase;     // context for error lines
    event        cmp_ev;

    lfo_top UUT (
        .i_EMUCLK (i_EMUCLK),
        .mrst_n   (mrst_n),
        .i_apb    (i_apb),
        .o_apb    (o_apb),
        .o_lfa    (o_lfa),
        .o_lfp    (o_lfp)
    );

    initial begin
        i_EMUCLK = 1'b0;
        forever #2 i_EMUCLK = ~i_EMUCLK;    // 4 ns period
    end

    // hard stop
    always @(posedge i_EMUCLK) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, run went past %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // {lfa, lfp} for a wave, phase and depth pair
    function automatic logic [15:0] exp_out(input logic [1:0] wave, input logic [7:0] p,
                                           input logic [6:0] amd, input logic [6:0] pmd);
        int am;
        int mag;
        int lfa;
        int lfp;
        if (wave == WAVE_SQUARE) begin
            am  = p[7] ? 0 : 127;
            mag = 127;
        end else if (wave == WAVE_TRI) begin
            am  = p[7] ? p[6:0] : 127 - p[6:0];
            mag = p[6] ? 2 * (63 - p[5:0]) : 2 * p[5:0];
        end else begin
            am  = 127 - p[7:1];     // saw and code 3
            mag = p[6:0];
        end
        lfa = (am * amd) >> 6;
        lfp = (pmd == 0) ? 128 : (p[7] * 128) + ((mag * pmd) >> 7);
        return {lfa[7:0], lfp[7:0]};
    endfunction

    // phase ticks in 1024 clocks
    function automatic int exp_ticks(input logic [7:0] lfrq);
        int preload;
        int steps;
        case (lfrq[7:4])
            4'd0:    preload = 'h1000;
            4'd1:    preload = 'h4000;
            default: preload = 'h8000 - (1 << (15 - lfrq[7:4])); // top e bits set
        endcase
        steps = 'h8000 - preload;   // prescaler steps per high wrap
        return (1024 * (16 + lfrq[3:0])) / (256 * steps);
    endfunction

    // output compare
    always @(cmp_ev) begin
        check_count += 2;
        assert (o_lfa === exp_lfa) else begin
            $display("[ERROR] o_lfa = %h, expected %h (phase %h)", o_lfa, exp_lfa, chk_phase);
            err_count++;
        end
        assert (o_lfp === exp_lfp) else begin
            $display("[ERROR] o_lfp = %h, expected %h (phase %h)", o_lfp, exp_lfp, chk_phase);
            err_count++;
        end
    end

    //////////////////////////////
    // bus and check tasks
    //////////////////////////////

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge i_EMUCLK);
    endtask

    task automatic apb_access(input logic wr, input logic [2:0] addr, input logic [7:0] data,
                              output logic [7:0] rd, output logic err);
        @(posedge i_EMUCLK);
        #0.5;
        i_apb.psel    = 1'b1;   // setup
        i_apb.penable = 1'b0;
        i_apb.pwrite  = wr;
        i_apb.paddr   = addr;
        i_apb.pwdata  = data;
        @(posedge i_EMUCLK);
        #0.5;
        i_apb.penable = 1'b1;   // access
        @(negedge i_EMUCLK);
        rd  = o_apb.prdata;
        err = o_apb.pslverr;
        check_flag(o_apb.pready === 1'b1, "pready was low in an access phase");
        @(posedge i_EMUCLK);
        #0.5;
        i_apb = '0;
    endtask

    task automatic apb_write(input logic [2:0] addr, input logic [7:0] data, output logic err);
        logic [7:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [2:0] addr, output logic [7:0] rd, output logic err);
        apb_access(1'b0, addr, 8'h00, rd, err);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("[ERROR] %s = %h, expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input logic ok, input string what);
        check_count++;
        assert (ok) else begin
            $display("%s", what);
            err_count++;
        end
    endtask

    task automatic check_outputs(input logic [1:0] wave, input logic [7:0] p,
                                 input logic [6:0] amd, input logic [6:0] pmd);
        @(negedge i_EMUCLK);
        {exp_lfa, exp_lfp} = exp_out(wave, p, amd, pmd);
        chk_phase = p;
        -> cmp_ev;
        @(posedge i_EMUCLK);
    endtask

    // slow the rate right down so the phase stops
    task automatic freeze_phase(output logic [7:0] ph);
        logic       err;
        logic [7:0] p1;
        apb_write(ADDR_LFRQ, 8'h00, err);
        wait_clocks(4);     // reload settles
        apb_read(ADDR_PHASE, p1, err);
        wait_clocks(40);
        apb_read(ADDR_PHASE, ph, err);
        check_flag(ph == p1, "phase kept moving after the rate was slowed down");
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %-12s %s, %0d errors", test_count, name,
                 (err_count == err_mark) ? "ok" : "bad", err_count - err_mark);
        err_mark = err_count;
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        logic       err;
        logic [7:0] rd;
        logic [7:0] ph;
        logic [7:0] p0;
        logic [6:0] amd;
        logic [6:0] pmd;
        logic [1:0] wave;
        logic [7:0] rates [3];
        int         adv;
        int         exp_adv;

        mrst_n      = 1'b0;
        i_apb       = '0;
        rng         = 32'h3342;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        err_mark    = 0;
        cycles      = 0;
        exp_lfa     = '0;
        exp_lfp     = '0;
        chk_phase   = '0;
        rates       = '{8'hF0, 8'hE0, 8'hF8};
        wait_clocks(10);
        #0.5;
        mrst_n = 1'b1;

        // reset state before the first pm half loads lfp
        @(negedge i_EMUCLK);
        check_byte("o_lfa", o_lfa, 8'h00);
        check_byte("o_lfp", o_lfp, 8'h00);
        apb_read(ADDR_LFRQ, rd, err);
        check_byte("lfrq", rd, 8'h00);
        check_flag(!err, "read of lfrq raised pslverr");
        apb_read(ADDR_DEPTH, rd, err);
        check_byte("amd", rd, 8'h00);
        apb_read(ADDR_CTRL, rd, err);
        check_byte("ctrl", rd, 8'h00);
        apb_read(ADDR_PHASE, rd, err);
        check_byte("phase", rd, 8'h00);
        apb_read(3'd5, rd, err);
        check_flag(err, "read at unmapped address 5 did not raise pslverr");
        end_test("reset");

        // register access where pmd shows only through lfp
        apb_write(ADDR_LFRQ, 8'h5A, err);
        check_flag(!err, "write to lfrq raised pslverr");
        apb_read(ADDR_LFRQ, rd, err);
        check_byte("lfrq", rd, 8'h5A);
        apb_write(ADDR_DEPTH, 8'h33, err);
        apb_write(ADDR_DEPTH, 8'h91, err);
        apb_read(ADDR_DEPTH, rd, err);
        check_byte("amd", rd, 8'h33);
        apb_write(ADDR_CTRL, 8'h06, err);
        apb_read(ADDR_CTRL, rd, err);
        check_byte("ctrl", rd, 8'h06);
        apb_write(ADDR_PHASE, 8'h12, err);
        check_flag(err, "write to the phase register did not raise pslverr");
        end_test("registers");

        // phase hold over a fast rate
        apb_write(ADDR_LFRQ, 8'hF0, err);
        for (int w = 0; w < 3; w++) begin
            rng = xorshift32(rng);
            amd = rng[6:0];
            pmd = rng[14:8];
            apb_write(ADDR_DEPTH, {1'b0, amd}, err);
            apb_write(ADDR_DEPTH, {1'b1, pmd}, err);
            apb_write(ADDR_CTRL, {5'd0, 1'b1, 2'(w)}, err);
            wait_clocks(4);
            apb_read(ADDR_PHASE, rd, err);
            check_byte("phase", rd, 8'h00);
            wait_clocks(40);
            check_outputs(2'(w), 8'h00, amd, pmd);
        end
        end_test("phase hold");

        // random frozen phases
        for (int i = 0; i < 12; i++) begin
            rng  = xorshift32(rng);
            amd  = rng[6:0];
            pmd  = (i == 5) ? 7'd0 : rng[14:8];     // one zero pm depth
            wave = rng[17:16];
            apb_write(ADDR_LFRQ, 8'hF0, err);
            wait_clocks(32 + rng[27:18]);
            apb_write(ADDR_DEPTH, {1'b0, amd}, err);
            apb_write(ADDR_DEPTH, {1'b1, pmd}, err);
            apb_write(ADDR_CTRL, {6'd0, wave}, err);
            freeze_phase(ph);
            check_outputs(wave, ph, amd, pmd);
        end
        end_test("waveforms");

        // phase advance over 1024 clocks
        apb_write(ADDR_CTRL, 8'h00, err);
        foreach (rates[r]) begin
            apb_write(ADDR_LFRQ, rates[r], err);
            wait_clocks(64);
            apb_read(ADDR_PHASE, p0, err);
            wait_clocks(1021);  // +3 clocks inside the reads
            apb_read(ADDR_PHASE, ph, err);
            adv     = 8'(ph - p0);
            exp_adv = exp_ticks(rates[r]);
            check_count++;
            assert (adv >= exp_adv - 2 && adv <= exp_adv + 2) else begin
                $display("[ERROR] phase advance = %h, expected %h (lfrq %h)",
                         adv, exp_adv, rates[r]);
                err_count++;
            end
        end
        end_test("rate");

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
lfo_pkg.sv
lfo_regs.sv
lfo_rate_gen.sv
lfo_phase_gen.sv
lfo_depth_mul.sv
lfo_top.sv
tb_lfo.sv
